/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ulx3s_top -f verilog.f > build.log 2>&1 \
    && ./obj_dir/Vtb_ulx3s_top > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation reported no failure"
exit 0

/* src/board_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Board definitions for the ULX3S
// Clock frequency, LED and button vector types
//////////////////////////////////////////////////////////////////////

package board_pkg;

    // On-board oscillator
    localparam int CLK_HZ = 25_000_000;

    // Eight user LEDs, active high
    typedef logic [7:0] led_t;

    // Seven buttons; btn[0] is the power/reset button on the board
    typedef logic [6:0] btn_t;

endpackage

/* src/echo_tx.sv */
//////////////////////////////////////////////////////////////////////
// Serial transmitter, 8N1, with pause input
// LED register holds the last byte accepted for sending
//////////////////////////////////////////////////////////////////////

module echo_tx #(
    parameter int FREQ_HZ   = board_pkg::CLK_HZ,
    parameter int BAUD_RATE = uart_pkg::DEFAULT_BAUD
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            pause_i,    // Holds off new bytes only
    input  logic            tx_valid_i,
    input  uart_pkg::data_t tx_data_i,
    output logic            tx_ready_o,
    output logic            txd_o,
    output board_pkg::led_t led_o
);
    import uart_pkg::*;

    localparam int CPB   = FREQ_HZ / BAUD_RATE;
    localparam int CNT_W = $clog2(CPB);

    tx_state_t        state_q;
    logic [CNT_W-1:0] cnt_q;   // Clocks into the current bit
    bit_idx_t         bit_q;
    data_t            shift_q; // LSB is on the line in TX_DATA
    logic             bit_end;
    logic             take;

    assign bit_end    = (cnt_q == CNT_W'(CPB - 1));
    assign tx_ready_o = (state_q == TX_IDLE) && !pause_i;
    assign take       = tx_valid_i && tx_ready_o;

    // Line level straight from the FSM
    always_comb begin
        case (state_q)
            TX_START: txd_o = 1'b0;
            TX_DATA:  txd_o = shift_q[0];
            default:  txd_o = 1'b1; // Idle and stop are mark
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            shift_q <= '0;
            led_o   <= '0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    cnt_q <= '0;
                    if (take) begin
                        shift_q <= tx_data_i;
                        led_o   <= tx_data_i; // Shown as soon as accepted
                        state_q <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= TX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        shift_q <= shift_q >> 1;
                        bit_q   <= bit_q + 1'b1;
                        if (bit_q == bit_idx_t'(7)) state_q <= TX_STOP;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) state_q <= TX_IDLE; // Ready next cycle
                    else cnt_q <= cnt_q + 1'b1;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

endmodule

/* src/rx_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Synchronous byte FIFO, register array
// Valid/ready on both sides, head entry read directly
//////////////////////////////////////////////////////////////////////

module rx_fifo #(
    parameter int DEPTH = 8 // Power of two, pointers wrap naturally
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            in_valid_i,
    input  uart_pkg::data_t in_data_i,
    output logic            in_ready_o,
    output logic            out_valid_o,
    output uart_pkg::data_t out_data_o,
    input  logic            out_ready_i
);
    import uart_pkg::*;

    localparam int AW = $clog2(DEPTH);

    data_t         mem_q [DEPTH]; // Byte storage
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;       // 0 .. DEPTH
    logic          push;
    logic          pop;

    assign in_ready_o  = (count_q != (AW+1)'(DEPTH)); // Not full
    assign out_valid_o = (count_q != '0);             // Not empty
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr_q] <= in_data_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* src/uart_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Serial framing definitions
// Data byte, bit index, receiver and transmitter state enums
//////////////////////////////////////////////////////////////////////

package uart_pkg;

    // Default line rate for the FTDI link
    localparam int DEFAULT_BAUD = 1_000_000;

    typedef logic [7:0] data_t;    // One 8N1 payload byte
    typedef logic [2:0] bit_idx_t; // Data bit position, LSB first

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,  // Line high, waiting for falling edge
        RX_START, // Half a bit to confirm the start bit
        RX_DATA,  // Eight data bits, sampled mid bit
        RX_STOP   // Stop bit check
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START, // Line driven low
        TX_DATA,  // Shift register LSB on the line
        TX_STOP   // Line high for one bit time
    } tx_state_t;

endpackage

/* src/uart_rx.sv */
//////////////////////////////////////////////////////////////////////
// Serial receiver, 8N1, counted from the system clock
// Two-flop input synchronizer, start and stop bit checks
//////////////////////////////////////////////////////////////////////

module uart_rx #(
    parameter int FREQ_HZ   = board_pkg::CLK_HZ,
    parameter int BAUD_RATE = uart_pkg::DEFAULT_BAUD
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            rxd_i,      // Asynchronous serial line
    output logic            rx_valid_o, // One-cycle offer, never held
    output uart_pkg::data_t rx_data_o,
    input  logic            rx_ready_i  // Low means the offered byte is lost
);
    import uart_pkg::*;

    localparam int CPB   = FREQ_HZ / BAUD_RATE; // Clocks per bit
    localparam int HALF  = CPB / 2;
    localparam int CNT_W = $clog2(CPB);

    logic [1:0]       sync_q;  // Metastability guard
    logic             rxd_s;
    rx_state_t        state_q;
    logic [CNT_W-1:0] cnt_q;   // Clocks into the current bit
    bit_idx_t         bit_q;
    data_t            shift_q; // Filled LSB first
    logic             bit_end; // Mid point of data or stop bit
    logic             half_end;

    assign rxd_s    = sync_q[1];
    assign bit_end  = (cnt_q == CNT_W'(CPB - 1));
    assign half_end = (cnt_q == CNT_W'(HALF - 1));

    // Offer in the cycle the stop bit is seen high
    assign rx_valid_o = (state_q == RX_STOP) && bit_end && rxd_s;
    assign rx_data_o  = shift_q; // Complete once in RX_STOP

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= 2'b11; // Idle line level
        end else begin
            sync_q <= {sync_q[0], rxd_i};
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            shift_q <= '0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rxd_s) state_q <= RX_START; // Falling edge
                end
                RX_START: begin
                    if (half_end) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        // Glitch shorter than half a bit goes back to idle
                        state_q <= rxd_s ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        shift_q <= {rxd_s, shift_q[7:1]};
                        if (bit_q == bit_idx_t'(7)) state_q <= RX_STOP;
                        bit_q <= bit_q + 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RX_STOP: begin
                    // Back to idle at mid stop bit, good or bad, so a
                    // back-to-back start edge is not missed
                    if (bit_end) begin
                        state_q <= RX_IDLE;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

endmodule

/* src/ulx3s_top.sv */
//////////////////////////////////////////////////////////////////////
// ULX3S board top for the serial echo
// FTDI receiver, byte FIFO and echo transmitter
//////////////////////////////////////////////////////////////////////

module ulx3s_top #(
    parameter int FREQ_HZ   = board_pkg::CLK_HZ,
    parameter int BAUD_RATE = uart_pkg::DEFAULT_BAUD,
    parameter int DEPTH     = 8
) (
    input  logic            clk_25mhz,  // Board oscillator, no PLL
    input  logic            rst_n_i,
    input  board_pkg::btn_t btn_i,
    output board_pkg::led_t led_o,
    input  logic            ftdi_txd_i, // Host to FPGA
    output logic            ftdi_rxd_o  // FPGA to host
);
    import uart_pkg::*;

    // Receiver to FIFO, one-cycle offer
    logic  rx_valid;
    data_t rx_data;
    logic  rx_ready;

    // FIFO to transmitter
    logic  tx_valid;
    data_t tx_data;
    logic  tx_ready;

    uart_rx #(
        .FREQ_HZ(FREQ_HZ),
        .BAUD_RATE(BAUD_RATE)
    ) u_uart_rx (
        .clk_i(clk_25mhz),
        .rst_n_i(rst_n_i),
        .rxd_i(ftdi_txd_i),
        .rx_valid_o(rx_valid),
        .rx_data_o(rx_data),
        .rx_ready_i(rx_ready)
    );

    rx_fifo #(
        .DEPTH(DEPTH)
    ) u_rx_fifo (
        .clk_i(clk_25mhz),
        .rst_n_i(rst_n_i),
        .in_valid_i(rx_valid),
        .in_data_i(rx_data),
        .in_ready_o(rx_ready),
        .out_valid_o(tx_valid),
        .out_data_o(tx_data),
        .out_ready_i(tx_ready)
    );

    echo_tx #(
        .FREQ_HZ(FREQ_HZ),
        .BAUD_RATE(BAUD_RATE)
    ) u_echo_tx (
        .clk_i(clk_25mhz),
        .rst_n_i(rst_n_i),
        .pause_i(btn_i[1]), // Held button backs up the FIFO
        .tx_valid_i(tx_valid),
        .tx_data_i(tx_data),
        .tx_ready_o(tx_ready),
        .txd_o(ftdi_rxd_o),
        .led_o(led_o)
    );

endmodule

/* tb/tb_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock source, period 10
//////////////////////////////////////////////////////////////////////

module tb_clock_gen #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #HALF_PERIOD clk_o = ~clk_o; // 50 % duty

endmodule

/* tb/tb_ulx3s_top.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the ULX3S serial echo
// Serial driver, echo decoder, model queue, tests and timeout
//////////////////////////////////////////////////////////////////////

module tb_ulx3s_top;
    import board_pkg::*;
    import uart_pkg::*;

    localparam int FREQ_HZ      = 25_000_000;
    localparam int BAUD_RATE    = 1_000_000;
    localparam int DEPTH        = 8;
    localparam int CPB          = FREQ_HZ / BAUD_RATE; // 25 clocks per bit
    localparam int HALF         = CPB / 2;
    localparam int FRAME_CYCLES = 10 * CPB;
    localparam int MAX_CYCLES   = 40 * FRAME_CYCLES * 2; // 40 frames, factor 2 slack

    logic  clk;
    logic  rst_n;
    btn_t  btn;
    led_t  led;
    logic  ftdi_txd;
    logic  ftdi_rxd;

    int    seed = 85510;
    data_t model_q [$];    // Bytes expected back, oldest first
    int    echo_count = 0; // Frames decoded on ftdi_rxd_o
    int    err_count = 0;
    int    check_count = 0;
    int    test_count = 0;
    int    cycle_count = 0;

    tb_clock_gen u_clock_gen (.clk_o(clk));

    ulx3s_top #(
        .FREQ_HZ(FREQ_HZ),
        .BAUD_RATE(BAUD_RATE),
        .DEPTH(DEPTH)
    ) u_ulx3s_top (
        .clk_25mhz(clk),
        .rst_n_i(rst_n),
        .btn_i(btn),
        .led_o(led),
        .ftdi_txd_i(ftdi_txd),
        .ftdi_rxd_o(ftdi_rxd)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_count++;
        end
    endtask

    function automatic data_t random_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // One bit time on the line, changed just after the clock edge
    task automatic drive_bit(input logic level);
        @(posedge clk);
        #1 ftdi_txd = level;
        repeat (CPB - 1) @(posedge clk);
    endtask

    task automatic send_frame(input data_t value, input logic stop_level);
        drive_bit(1'b0); // Start
        for (int i = 0; i < 8; i++) begin
            drive_bit(value[i]); // LSB first
        end
        drive_bit(stop_level);
        if (!stop_level) begin
            drive_bit(1'b1); // Idle gap lets the receiver settle
            drive_bit(1'b1);
        end
    endtask

    task automatic wait_echoes(input int target);
        while (echo_count < target) @(posedge clk); // Watchdog bounds this
    endtask

    task automatic report_test(input string name, input int err_base);
        test_count++;
        $display("Test %-10s done, %0d errors", name, err_count - err_base);
    endtask

    // Echo decoder, samples on the falling clock edge
    initial begin : decoder
        data_t got;
        data_t exp;
        forever begin
            @(negedge clk);
            if (rst_n && ftdi_rxd === 1'b0) begin
                repeat (HALF) @(negedge clk); // Mid start bit
                if (ftdi_rxd !== 1'b0) begin
                    $display("Echo start bit went high before its midpoint");
                    err_count++;
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (CPB) @(negedge clk);
                        got[i] = ftdi_rxd;
                    end
                    repeat (CPB) @(negedge clk); // Mid stop bit
                    if (ftdi_rxd !== 1'b1) begin
                        $display("Echo stop bit was low");
                        err_count++;
                    end
                    echo_count++;
                    if (model_q.size() == 0) begin
                        $display("Echo byte 0x%02h arrived with none expected", got);
                        err_count++;
                    end else begin
                        exp = model_q.pop_front();
                        check("ftdi_rxd_o byte", 32'(got), 32'(exp));
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout, run passed %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        data_t b;
        int    base;
        int    err_base;
        rst_n    = 1'b0;
        btn      = '0;
        ftdi_txd = 1'b1; // Idle line
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        // Outputs straight after reset
        err_base = err_count;
        @(negedge clk);
        check("ftdi_rxd_o", 32'(ftdi_rxd), 32'h1);
        check("led_o", 32'(led), 32'h0);
        report_test("reset", err_base);

        // Single byte round trip
        err_base = err_count;
        base     = echo_count;
        b        = random_byte();
        model_q.push_back(b);
        send_frame(b, 1'b1);
        wait_echoes(base + 1);
        @(negedge clk);
        check("led_o", 32'(led), 32'(b));
        report_test("single", err_base);

        // Twenty frames back to back
        err_base = err_count;
        base     = echo_count;
        for (int i = 0; i < 20; i++) begin
            b = random_byte();
            model_q.push_back(b);
            send_frame(b, 1'b1);
        end
        wait_echoes(base + 20);
        repeat (FRAME_CYCLES) @(posedge clk); // No echo after the last one
        check("echo count after stream", 32'(echo_count), 32'(base + 20));
        report_test("stream", err_base);

        // Held pause, FIFO fills and drops the rest
        err_base = err_count;
        base     = echo_count;
        @(posedge clk);
        #1 btn[1] = 1'b1;
        for (int i = 0; i < 12; i++) begin
            b = random_byte();
            if (i < DEPTH) model_q.push_back(b); // Later bytes find the FIFO full
            send_frame(b, 1'b1);
        end
        drive_bit(1'b1);
        check("echo count while paused", 32'(echo_count), 32'(base));
        @(posedge clk);
        #1 btn[1] = 1'b0;
        wait_echoes(base + DEPTH);
        repeat (3 * FRAME_CYCLES) @(posedge clk); // Quiet window
        check("echo count after pause", 32'(echo_count), 32'(base + DEPTH));
        report_test("pause", err_base);

        // Low stop bit, then a good frame
        err_base = err_count;
        base     = echo_count;
        send_frame(random_byte(), 1'b0);
        b = random_byte();
        model_q.push_back(b);
        send_frame(b, 1'b1);
        wait_echoes(base + 1);
        repeat (FRAME_CYCLES) @(posedge clk);
        @(negedge clk);
        check("echo count after framing error", 32'(echo_count), 32'(base + 1));
        check("led_o", 32'(led), 32'(b));
        report_test("framing", err_base);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* tb/ulx3s_top_props.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the byte FIFO
// Occupancy limit, valid and data hold under back-pressure
//////////////////////////////////////////////////////////////////////

module ulx3s_top_props #(
    parameter int DEPTH = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [$clog2(DEPTH):0]     count_i,
    input  logic                       out_valid_i,
    input  uart_pkg::data_t            out_data_i,
    input  logic                       out_ready_i
);
    localparam int CW = $clog2(DEPTH) + 1;
    localparam logic [CW-1:0] FULL = CW'(DEPTH);

    a_count_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_i <= FULL)
        else $error("FIFO occupancy above depth");

    // Valid stays up until the head is taken
    a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_i && !out_ready_i) |=> out_valid_i)
        else $error("FIFO valid dropped before a transfer");

    a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_i && !out_ready_i) |=> $stable(out_data_i))
        else $error("FIFO head data changed while stalled");

endmodule

bind rx_fifo ulx3s_top_props #(
    .DEPTH(DEPTH)
) u_fifo_props (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .count_i(count_q),
    .out_valid_i(out_valid_o),
    .out_data_i(out_data_o),
    .out_ready_i(out_ready_i)
);

/* verilog.f */
src/board_pkg.sv
src/uart_pkg.sv
src/uart_rx.sv
src/rx_fifo.sv
src/echo_tx.sv
src/ulx3s_top.sv
tb/tb_clock_gen.sv
tb/ulx3s_top_props.sv
tb/tb_ulx3s_top.sv
